//--- filelist.f
+incdir+hdl
hdl/devinfo_pkg.sv
hdl/devinfo_info_if.sv
hdl/boot_timer.sv
hdl/dna_serial_reader.sv
hdl/icap_idcode_reader.sv
hdl/devinfo_regs.sv
hdl/devinfo_top.sv
verif/tb_clock_gen.sv
verif/devinfo_assert.sv
verif/tb_devinfo.sv

//--- hdl/boot_timer.sv
`timescale 1ns/1ps
`include "devinfo_settings.svh"

module boot_timer (
	input logic apb,
	input logic rst_icap_n,
	output logic boot_done
);

	// Wide enough to hold the full delay
	localparam int CW = $clog2(`DEVINFO_BOOT_CYCLES + 1);

	logic [CW-1:0] boot_count;

	// Hold off the configuration port until it has settled
	always_ff @(posedge apb) begin
		if (!rst_icap_n) begin
			boot_count <= '0;
			boot_done <= 1'b0;
		end else if (!boot_done) begin
			// Last count, boot done on this edge
			if (boot_count == CW'(`DEVINFO_BOOT_CYCLES - 1))
				boot_done <= 1'b1;
			boot_count <= boot_count + 1'b1;
		end
	end

endmodule

//--- hdl/devinfo_info_if.sv
`timescale 1ns/1ps

interface devinfo_info_if;

	// Die serial from the DNA port
	devinfo_pkg::serial_t serial;
	// Low until serial is final, then high until reset
	logic serial_valid;

	// IDCODE from the ICAP read
	devinfo_pkg::idcode_t idcode;
	logic idcode_valid;

	// DNA reader side
	modport dna_src (
		output serial,
		output serial_valid
	);

	// ICAP reader side
	modport icap_src (
		output idcode,
		output idcode_valid
	);

	// Register file sees everything
	modport regs_sink (
		input serial, serial_valid, idcode, idcode_valid
	);

endinterface

//--- hdl/devinfo_pkg.sv
package devinfo_pkg;

	// APB register offsets
	typedef enum logic [7:0] {
		// Bit 0 IDCODE valid, bit 1 serial valid
		REG_STATUS   = 8'h00,
		REG_IDCODE   = 8'h04,
		// Die serial bits 63:32
		REG_SERIAL_H = 8'h0c,
		// Die serial bits 31:0
		REG_SERIAL_L = 8'h10,
		REG_USERCODE = 8'h14,
		REG_SCRATCH  = 8'h18
	} regid_t;

	// Die serial, upper 7 bits always zero
	typedef logic [63:0] serial_t;

	typedef logic [31:0] idcode_t;

	// DNA port reader
	typedef enum logic [1:0] {
		DNA_BOOT = 2'h0,
		DNA_READ = 2'h1,
		DNA_DONE = 2'h2
	} dna_state_t;

	// ICAP IDCODE reader
	typedef enum logic [2:0] {
		ICAP_BOOT_HOLD = 3'h0,
		ICAP_SYNC      = 3'h1,
		ICAP_NOP       = 3'h2,
		ICAP_HEADER    = 3'h3,
		ICAP_PIPE      = 3'h4,
		ICAP_READ      = 3'h5,
		ICAP_DONE      = 3'h6
	} icap_state_t;

endpackage

//--- hdl/devinfo_regs.sv
`timescale 1ns/1ps
`include "devinfo_settings.svh"

module devinfo_regs (
	input logic apb,
	input logic rst_icap_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	input logic [31:0] usercode,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	devinfo_info_if.regs_sink info
);

	logic [31:0] scratch;
	logic scratch_wr;

	////////////////////////////////////////////////////////////////////////////
	// Scratch register

	// Taken at the edge closing the access phase
	assign scratch_wr = pready && pwrite && (paddr == devinfo_pkg::REG_SCRATCH);

	always_ff @(posedge apb) begin
		if (!rst_icap_n)
			scratch <= `DEVINFO_SCRATCH_INIT;
		else if (scratch_wr)
			scratch <= pwdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// Readback and error decode

	always_comb begin
		// No wait states
		pready = psel && penable;
		prdata = '0;
		pslverr = 1'b0;
		if (pready) begin
			if (!pwrite) begin
				case (paddr)
					devinfo_pkg::REG_STATUS:
						prdata = {30'h0, info.serial_valid, info.idcode_valid};
					devinfo_pkg::REG_IDCODE: prdata = info.idcode;
					devinfo_pkg::REG_SERIAL_H: prdata = info.serial[63:32];
					devinfo_pkg::REG_SERIAL_L: prdata = info.serial[31:0];
					devinfo_pkg::REG_USERCODE: prdata = usercode;
					devinfo_pkg::REG_SCRATCH: prdata = scratch;
					// Hole in the map
					default: pslverr = 1'b1;
				endcase
			end else if (paddr != devinfo_pkg::REG_SCRATCH) begin
				// Everything but scratch is read only
				pslverr = 1'b1;
			end
		end
	end

endmodule

//--- hdl/devinfo_settings.svh
`ifndef DEVINFO_SETTINGS_SVH
`define DEVINFO_SETTINGS_SVH

// Cycles from reset release until the configuration port may be used
`define DEVINFO_BOOT_CYCLES 16

// Die serial length on the DNA port
`define DEVINFO_DNA_BITS 57

// ICAP command stream words
`define DEVINFO_ICAP_SYNC 32'haa995566
`define DEVINFO_ICAP_NOP 32'h20000000
// Type 1 read, IDCODE register, one word
`define DEVINFO_ICAP_RD_IDCODE 32'h28018001
// Type 1 write, CMD register, one word
`define DEVINFO_ICAP_WR_CMD 32'h30008001
`define DEVINFO_ICAP_DESYNC 32'h0000000d

// Scratch register value out of reset
`define DEVINFO_SCRATCH_INIT 32'h5555aaaa

`endif

//--- hdl/devinfo_top.sv
`timescale 1ns/1ps

module devinfo_top (
	input logic apb,
	input logic rst_icap_n,
	// APB completer
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// DNA port pins
	output logic dna_read,
	output logic dna_shift,
	input logic dna_dout,
	// ICAP pins
	output logic icap_cs_n,
	output logic icap_wr_n,
	output logic [31:0] icap_din,
	input logic [31:0] icap_dout,
	// User access word
	input logic [31:0] usercode
);

	logic boot_done;

	// Device facts from readers to registers
	devinfo_info_if info ();

	boot_timer u_boot_timer (
		.apb(apb),
		.rst_icap_n(rst_icap_n),
		.boot_done(boot_done)
	);

	dna_serial_reader u_dna_reader (
		.apb(apb),
		.rst_icap_n(rst_icap_n),
		.boot_done(boot_done),
		.dna_dout(dna_dout),
		.dna_read(dna_read),
		.dna_shift(dna_shift),
		.info(info.dna_src)
	);

	icap_idcode_reader u_icap_reader (
		.apb(apb),
		.rst_icap_n(rst_icap_n),
		.boot_done(boot_done),
		.icap_dout(icap_dout),
		.icap_cs_n(icap_cs_n),
		.icap_wr_n(icap_wr_n),
		.icap_din(icap_din),
		.info(info.icap_src)
	);

	devinfo_regs u_regs (
		.apb(apb),
		.rst_icap_n(rst_icap_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.usercode(usercode),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.info(info.regs_sink)
	);

endmodule

//--- hdl/dna_serial_reader.sv
`timescale 1ns/1ps
`include "devinfo_settings.svh"

module dna_serial_reader (
	input logic apb,
	input logic rst_icap_n,
	input logic boot_done,
	input logic dna_dout,
	output logic dna_read,
	output logic dna_shift,
	devinfo_info_if.dna_src info
);

	localparam int CW = $clog2(`DEVINFO_DNA_BITS + 1);

	devinfo_pkg::dna_state_t state;
	// Shift pulses issued so far
	logic [CW-1:0] shift_cnt;
	logic [`DEVINFO_DNA_BITS-1:0] dna_bits;

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge apb) begin
		if (!rst_icap_n) begin
			state <= devinfo_pkg::DNA_BOOT;
			dna_read <= 1'b0;
			dna_shift <= 1'b0;
			shift_cnt <= '0;
			info.serial_valid <= 1'b0;
		end else begin
			// Read and shift are single-cycle strobes
			dna_read <= 1'b0;
			dna_shift <= 1'b0;
			case (state)
				// Load the DNA register once boot is over
				devinfo_pkg::DNA_BOOT: begin
					if (boot_done) begin
						dna_read <= 1'b1;
						state <= devinfo_pkg::DNA_READ;
					end
				end
				// One shift per bit, MSB comes out first
				devinfo_pkg::DNA_READ: begin
					if (shift_cnt != CW'(`DEVINFO_DNA_BITS)) begin
						dna_shift <= 1'b1;
						shift_cnt <= shift_cnt + 1'b1;
					end else
						state <= devinfo_pkg::DNA_DONE;
				end
				// Serial final, flag stays up
				devinfo_pkg::DNA_DONE: info.serial_valid <= 1'b1;
				default: state <= devinfo_pkg::DNA_BOOT;
			endcase
		end
	end

	// Sample under each shift, first bit ends up at the top
	always_ff @(posedge apb) begin
		if (dna_shift)
			dna_bits <= {dna_bits[`DEVINFO_DNA_BITS-2:0], dna_dout};
	end

	assign info.serial = devinfo_pkg::serial_t'(dna_bits);

endmodule

//--- hdl/icap_idcode_reader.sv
`timescale 1ns/1ps
`include "devinfo_settings.svh"

module icap_idcode_reader (
	input logic apb,
	input logic rst_icap_n,
	input logic boot_done,
	input logic [31:0] icap_dout,
	output logic icap_cs_n,
	output logic icap_wr_n,
	output logic [31:0] icap_din,
	devinfo_info_if.icap_src info
);

	devinfo_pkg::icap_state_t state;
	// Step counter, reused by every state
	logic [3:0] count;
	// Command word before the port bit order swap
	logic [31:0] din_word;

	// ICAP wants each byte with its bits mirrored
	function automatic logic [31:0] bit_rev_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			for (int g = 0; g < 8; g++)
				r[b*8 + g] = w[b*8 + 7 - g];
		end
		return r;
	endfunction

	assign icap_din = bit_rev_bytes(din_word);

	////////////////////////////////////////////////////////////////////////////
	// Command sequencer

	always_ff @(posedge apb) begin
		if (!rst_icap_n) begin
			state <= devinfo_pkg::ICAP_BOOT_HOLD;
			icap_cs_n <= 1'b1;
			icap_wr_n <= 1'b1;
			count <= '0;
			din_word <= `DEVINFO_ICAP_NOP;
			info.idcode_valid <= 1'b0;
		end else begin
			case (state)
				// Wait for the port to come up, then select it for writing
				devinfo_pkg::ICAP_BOOT_HOLD: begin
					if (boot_done) begin
						icap_cs_n <= 1'b0;
						icap_wr_n <= 1'b0;
						state <= devinfo_pkg::ICAP_SYNC;
					end
				end
				devinfo_pkg::ICAP_SYNC: begin
					din_word <= `DEVINFO_ICAP_SYNC;
					state <= devinfo_pkg::ICAP_NOP;
				end
				// Two no-ops to cover the hazard after sync
				devinfo_pkg::ICAP_NOP: begin
					din_word <= `DEVINFO_ICAP_NOP;
					count <= count + 1'b1;
					if (count == 4'd1) begin
						count <= '0;
						state <= devinfo_pkg::ICAP_HEADER;
					end
				end
				devinfo_pkg::ICAP_HEADER: begin
					din_word <= `DEVINFO_ICAP_RD_IDCODE;
					state <= devinfo_pkg::ICAP_PIPE;
				end
				// Flush, deselect, turn around to read, reselect
				devinfo_pkg::ICAP_PIPE: begin
					din_word <= `DEVINFO_ICAP_NOP;
					count <= count + 1'b1;
					if (count == 4'd2)
						icap_cs_n <= 1'b1;
					if (count == 4'd3)
						icap_wr_n <= 1'b1;
					if (count == 4'd4) begin
						icap_cs_n <= 1'b0;
						count <= '0;
						state <= devinfo_pkg::ICAP_READ;
					end
				end
				// Read latency, word sampled at step 3
				devinfo_pkg::ICAP_READ: begin
					count <= count + 1'b1;
					if (count == 4'd4)
						info.idcode_valid <= 1'b1;
					if (count == 4'd8) begin
						count <= '0;
						state <= devinfo_pkg::ICAP_DONE;
					end
				end
				// Back to write mode, desync, then release
				devinfo_pkg::ICAP_DONE: begin
					if (count < 4'd9)
						count <= count + 1'b1;
					if (count == 4'd0)
						icap_cs_n <= 1'b1;
					if (count == 4'd1)
						icap_wr_n <= 1'b0;
					if (count == 4'd2) begin
						din_word <= `DEVINFO_ICAP_NOP;
						icap_cs_n <= 1'b0;
					end
					if (count == 4'd4)
						din_word <= `DEVINFO_ICAP_WR_CMD;
					if (count == 4'd5)
						din_word <= `DEVINFO_ICAP_DESYNC;
					if (count == 4'd6)
						din_word <= `DEVINFO_ICAP_NOP;
					if (count == 4'd8)
						icap_cs_n <= 1'b1;
				end
				default: state <= devinfo_pkg::ICAP_BOOT_HOLD;
			endcase
		end
	end

	// IDCODE capture
	always_ff @(posedge apb) begin
		if (state == devinfo_pkg::ICAP_READ && count == 4'd3)
			info.idcode <= bit_rev_bytes(icap_dout);
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the devinfo testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_devinfo -f filelist.f \
	-o sim_devinfo > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_devinfo > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

//--- verif/devinfo_assert.sv
`timescale 1ns/1ps

module devinfo_assert (
	input logic apb,
	input logic rst_icap_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic dna_read,
	input logic dna_shift,
	input logic icap_cs_n,
	input logic serial_valid,
	input logic idcode_valid
);

	////////////////////////////////////////////////////////////////////////////
	// APB handshake

	// No wait states
	ap_pready_follows: assert property (@(posedge apb) pready == (psel && penable))
		else $error("pready does not follow psel and penable");

	ap_slverr_in_access: assert property (@(posedge apb) pslverr |-> pready)
		else $error("pslverr high outside the access phase");

	////////////////////////////////////////////////////////////////////////////
	// Reader pins and flags

	ap_dna_strobes: assert property (@(posedge apb) !(dna_read && dna_shift))
		else $error("dna_shift overlaps dna_read");

	// Chip select released by reset
	ap_icap_idle: assert property (@(posedge apb) !rst_icap_n |=> icap_cs_n)
		else $error("icap_cs_n low after reset");

	// Sticky once final
	ap_serial_sticky: assert property (
		@(posedge apb) disable iff (!rst_icap_n) !$fell(serial_valid))
		else $error("serial_valid fell outside reset");

	ap_idcode_sticky: assert property (
		@(posedge apb) disable iff (!rst_icap_n) !$fell(idcode_valid))
		else $error("idcode_valid fell outside reset");

endmodule

bind devinfo_top devinfo_assert u_assert (
	.apb(apb),
	.rst_icap_n(rst_icap_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.dna_read(dna_read),
	.dna_shift(dna_shift),
	.icap_cs_n(icap_cs_n),
	.serial_valid(info.serial_valid),
	.idcode_valid(info.idcode_valid)
);

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic apb,
	output logic rst_icap_n
);

	// 20 ns period
	initial begin
		apb = 1'b0;
		forever #10 apb = ~apb;
	end

	// Four cycles of reset, released on a falling edge
	initial begin
		rst_icap_n = 1'b0;
		repeat (4) @(posedge apb);
		@(negedge apb);
		rst_icap_n = 1'b1;
	end

endmodule

//--- verif/tb_devinfo.sv
`timescale 1ns/1ps
`include "devinfo_settings.svh"

module tb_devinfo;

	// Device facts presented by the models
	localparam logic [56:0] DNA_VALUE = 57'h0adbeef_c0def00d;
	localparam logic [31:0] IDCODE_VALUE = 32'h0372c093;
	localparam logic [31:0] USERCODE_VALUE = 32'h12345678;
	// Boot, readers, about 60 accesses and margin
	localparam int TIMEOUT_CYCLES = 400;
	// ICAP commands in the order they must be written, no-ops aside
	localparam logic [31:0] ICAP_CMDS [4] = '{`DEVINFO_ICAP_SYNC, `DEVINFO_ICAP_RD_IDCODE,
		`DEVINFO_ICAP_WR_CMD, `DEVINFO_ICAP_DESYNC};

	logic apb;
	logic rst_icap_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic dna_read;
	logic dna_shift;
	logic dna_dout = 1'b0;
	logic icap_cs_n;
	logic icap_wr_n;
	logic [31:0] icap_din;
	logic [31:0] icap_dout = 32'h0;
	logic [31:0] usercode;

	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	// DNA model state
	int dna_index = `DEVINFO_DNA_BITS - 1;
	logic shift_pending = 1'b0;
	// ICAP commands seen so far
	int icap_step = 0;

	tb_clock_gen u_clock_gen (
		.apb(apb),
		.rst_icap_n(rst_icap_n)
	);

	devinfo_top dut (
		.apb(apb),
		.rst_icap_n(rst_icap_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.dna_read(dna_read),
		.dna_shift(dna_shift),
		.dna_dout(dna_dout),
		.icap_cs_n(icap_cs_n),
		.icap_wr_n(icap_wr_n),
		.icap_din(icap_din),
		.icap_dout(icap_dout),
		.usercode(usercode)
	);

	// Mirror bits inside each byte, as on the ICAP data pins
	function automatic logic [31:0] byte_mirror(input logic [31:0] w);
		logic [31:0] all_rev;
		all_rev = {<<{w}};
		return {<<8{all_rev}};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port models

	// DNA port, load on read, next lower bit after each sampled shift
	always @(negedge apb) begin
		if (dna_read)
			dna_index = `DEVINFO_DNA_BITS - 1;
		else if (shift_pending && dna_index > 0)
			dna_index = dna_index - 1;
		shift_pending = dna_shift;
		dna_dout = DNA_VALUE[dna_index];
	end

	// ICAP drives the IDCODE whenever the port is in read mode
	// Command words written with chip select low must come in order
	always @(negedge apb) begin
		logic [31:0] word;
		word = byte_mirror(icap_din);
		if (icap_cs_n === 1'b0 && icap_wr_n === 1'b0 && word !== `DEVINFO_ICAP_NOP) begin
			checks++;
			assert (icap_step < 4 && word === ICAP_CMDS[icap_step]) else begin
				$display("error %0t ns: ICAP command %08h out of sequence", $time, word);
				errors++;
			end
			icap_step++;
		end
		icap_dout = icap_wr_n ? byte_mirror(IDCODE_VALUE) : 32'h0;
	end

	always @(posedge apb) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// APB master

	// Setup, access, wait for pready
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge apb);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge apb);
		penable = 1'b1;
		@(posedge apb);
		while (!pready && waits < 8) begin
			waits++;
			@(posedge apb);
		end
		assert (pready) else begin
			$display("no pready within 8 cycles of the access phase at %0t ns", $time);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge apb);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata,
			output logic err);
		apb_access(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata,
			output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, wdata, unused, err);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_error_flag(input string what, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			$display("error %0t ns: %s gave pslverr %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0] rd;
		logic err;
		logic [31:0] wval;
		int polls;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		usercode = USERCODE_VALUE;
		void'($urandom(92057));
		wait (rst_icap_n === 1'b1);

		// Nothing discovered before boot
		read_reg(devinfo_pkg::REG_STATUS, rd, err);
		check_value("status before boot", rd, 32'h0);
		check_error_flag("status read", err, 1'b0);

		// Poll until both readers finish
		polls = 0;
		read_reg(devinfo_pkg::REG_STATUS, rd, err);
		while (rd !== 32'h3 && polls < 60) begin
			polls++;
			read_reg(devinfo_pkg::REG_STATUS, rd, err);
		end
		check_value("status after boot", rd, 32'h3);

		read_reg(devinfo_pkg::REG_IDCODE, rd, err);
		check_value("idcode", rd, IDCODE_VALUE);
		// First DNA bit out is bit 56
		read_reg(devinfo_pkg::REG_SERIAL_H, rd, err);
		check_value("serial high", rd, {7'h0, DNA_VALUE[56:32]});
		read_reg(devinfo_pkg::REG_SERIAL_L, rd, err);
		check_value("serial low", rd, DNA_VALUE[31:0]);
		read_reg(devinfo_pkg::REG_USERCODE, rd, err);
		check_value("usercode", rd, USERCODE_VALUE);

		read_reg(devinfo_pkg::REG_SCRATCH, rd, err);
		check_value("scratch after reset", rd, `DEVINFO_SCRATCH_INIT);
		for (int i = 0; i < 8; i++) begin
			wval = $urandom;
			write_reg(devinfo_pkg::REG_SCRATCH, wval, err);
			check_error_flag("scratch write", err, 1'b0);
			read_reg(devinfo_pkg::REG_SCRATCH, rd, err);
			check_value("scratch readback", rd, wval);
		end

		// Hole in the map, then a write to a read-only register
		read_reg(8'h08, rd, err);
		check_error_flag("read of offset 08", err, 1'b1);
		write_reg(devinfo_pkg::REG_IDCODE, ~IDCODE_VALUE, err);
		check_error_flag("write to idcode", err, 1'b1);
		read_reg(devinfo_pkg::REG_IDCODE, rd, err);
		check_value("idcode after write", rd, IDCODE_VALUE);

		// Whole ICAP command stream written and the port released
		checks++;
		assert (icap_step == 4 && icap_cs_n === 1'b1) else begin
			$display("ICAP sequence incomplete or chip select still low at the end");
			errors++;
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
